/* hdl/rv_ctrl_gen.sv */
`timescale 1ns/1ns

module rv_ctrl_gen
(
    input  rv_decode_pkg::instr_grp_t i_grp,
    input  rv_decode_pkg::alu_op_e    i_alu_op,
    output rv_decode_pkg::alu_res_t   o_alu_res,
    output rv_decode_pkg::alu_ctrl_t  o_alu_ctrl,
    output rv_decode_pkg::res_src_t   o_res_src,
    output rv_decode_pkg::src_op1_t   o_op1_src,
    output rv_decode_pkg::src_op2_t   o_op2_src,
    output logic                      o_reg_write
);

    import rv_decode_pkg::*;

    logic use_imm;

    // result group, stays zero for ALU_NONE
    assign o_alu_res.cmp   = i_alu_op inside {SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};
    assign o_alu_res.bits  = i_alu_op inside {AND, OR, XOR};
    assign o_alu_res.shift = i_alu_op inside {SLL, SRL, SRA};
    assign o_alu_res.arith = i_alu_op inside {ADD, SUB};

    // compare flavour
    assign o_alu_ctrl.cmp_eq       = i_alu_op inside {BEQ, BNE};
    assign o_alu_ctrl.cmp_lts      = i_alu_op inside {SLT, BLT, BGE};
    assign o_alu_ctrl.cmp_ltu      = i_alu_op inside {SLTU, BLTU, BGEU};
    assign o_alu_ctrl.cmp_inversed = i_alu_op inside {BNE, BGE, BGEU};

    assign o_alu_ctrl.bits_and = (i_alu_op == AND);
    assign o_alu_ctrl.bits_or  = (i_alu_op == OR);
    assign o_alu_ctrl.bits_xor = (i_alu_op == XOR);

    assign o_alu_ctrl.arith_shl          = (i_alu_op == SLL);
    assign o_alu_ctrl.arith_shr          = i_alu_op inside {SRL, SRA};
    assign o_alu_ctrl.arith_sub          = (i_alu_op == SUB);
    assign o_alu_ctrl.arith_add          = (i_alu_op == ADD);
    assign o_alu_ctrl.shift_arithmetical = (i_alu_op == SRA);

    // auipc and jal add to the pc
    assign o_op1_src.pc = i_grp.auipc || i_grp.jal;
    assign o_op1_src.r  = !(i_grp.auipc || i_grp.jal);

    assign use_imm = i_grp.jalr || i_grp.load || i_grp.imm || i_grp.lui
                  || i_grp.auipc || i_grp.store;

    assign o_op2_src.j = i_grp.jal;
    assign o_op2_src.i = use_imm;
    assign o_op2_src.r = !(use_imm || i_grp.jal);

    // jumps write back the return address
    assign o_res_src.memory  = i_grp.load;
    assign o_res_src.pc_next = i_grp.jal || i_grp.jalr;
    assign o_res_src.alu     = !(i_grp.load || i_grp.jal || i_grp.jalr);

    assign o_reg_write = i_grp.load || i_grp.imm || i_grp.reg_op || i_grp.lui
                      || i_grp.auipc || i_grp.jal || i_grp.jalr || i_grp.sys;

endmodule

/* hdl/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // major opcodes, instruction bits 6..2
    localparam logic [4:0] OPC_LD   = 5'b00000;
    localparam logic [4:0] OPC_STR  = 5'b01000;
    localparam logic [4:0] OPC_ARI  = 5'b00100;
    localparam logic [4:0] OPC_ARR  = 5'b01100;
    localparam logic [4:0] OPC_AUI  = 5'b00101;
    localparam logic [4:0] OPC_LUI  = 5'b01101;
    localparam logic [4:0] OPC_B    = 5'b11000;
    localparam logic [4:0] OPC_JAL  = 5'b11011;
    localparam logic [4:0] OPC_JALR = 5'b11001;
    localparam logic [4:0] OPC_SYS  = 5'b11100;

    // low opcode bits of a 32-bit instruction
    localparam logic [1:0] OPC_FULL = 2'b11;

    localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
    localparam logic [11:0] FUNCT12_MRET   = 12'h302;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // one flag per major opcode, at most one set
    typedef struct packed {
        logic load;
        logic store;
        logic imm;
        logic reg_op;
        logic branch;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic sys;
    } instr_grp_t;

    typedef enum logic [4:0] {
        ALU_NONE,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } alu_op_e;

    // result group, one-hot or zero when the ALU is idle
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    typedef struct packed {
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic pc;
        logic r;
    } src_op1_t;

    typedef struct packed {
        logic j;
        logic i;
        logic r;
    } src_op2_t;

endpackage

/* hdl/rv_decode_top.sv */
`timescale 1ns/1ns

module rv_decode_top
#(
    parameter int EXTENSION_ZICSR = 0
)
(
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    input  logic                                 i_stall,
    input  logic                                 i_flush,
    input  logic [rv_decode_pkg::XLEN-1:0]       i_instruction,
    input  logic [rv_decode_pkg::XLEN-1:0]       i_pc,
    output logic [rv_decode_pkg::CSR_ADDR_W-1:0] o_csr_idx,
    output logic [4:0]                           o_csr_imm,
    output logic                                 o_csr_imm_sel,
    output logic                                 o_csr_write,
    output logic                                 o_csr_set,
    output logic                                 o_csr_clear,
    output logic                                 o_csr_read,
    output logic                                 o_csr_ebreak,
    output logic [rv_decode_pkg::XLEN-1:0]       o_pc,
    output logic [rv_decode_pkg::XLEN-1:0]       o_pc_next,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_decode_pkg::XLEN-1:0]       o_imm_i,
    output logic [rv_decode_pkg::XLEN-1:0]       o_imm_j,
    output rv_decode_pkg::alu_res_t              o_alu_res,
    output rv_decode_pkg::alu_ctrl_t             o_alu_ctrl,
    output logic [2:0]                           o_funct3,
    output rv_decode_pkg::res_src_t              o_res_src,
    output logic                                 o_reg_write,
    output rv_decode_pkg::src_op1_t              o_op1_src,
    output rv_decode_pkg::src_op2_t              o_op2_src,
    output logic                                 o_inst_mret,
    output logic                                 o_inst_jalr,
    output logic                                 o_inst_jal,
    output logic                                 o_inst_branch,
    output logic                                 o_inst_store,
    output logic                                 o_inst_supported
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] instruction;
    instr_grp_t      grp;
    alu_op_e         alu_op;

    rv_stage_reg stage_reg_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .o_instruction (instruction),
        .o_pc          (o_pc),
        .o_pc_next     (o_pc_next)
    );

    rv_op_decode
    #(
        .EXTENSION_ZICSR (EXTENSION_ZICSR)
    )
    op_decode_i
    (
        .i_instruction    (instruction),
        .o_grp            (grp),
        .o_alu_op         (alu_op),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rd             (o_rd),
        .o_funct3         (o_funct3),
        .o_csr_idx        (o_csr_idx),
        .o_csr_imm        (o_csr_imm),
        .o_csr_imm_sel    (o_csr_imm_sel),
        .o_csr_write      (o_csr_write),
        .o_csr_set        (o_csr_set),
        .o_csr_clear      (o_csr_clear),
        .o_csr_read       (o_csr_read),
        .o_csr_ebreak     (o_csr_ebreak),
        .o_inst_mret      (o_inst_mret),
        .o_inst_branch    (o_inst_branch),
        .o_inst_jal       (o_inst_jal),
        .o_inst_jalr      (o_inst_jalr),
        .o_inst_store     (o_inst_store),
        .o_inst_supported (o_inst_supported)
    );

    rv_imm_gen imm_gen_i
    (
        .i_instruction (instruction),
        .i_grp         (grp),
        .o_imm_i       (o_imm_i),
        .o_imm_j       (o_imm_j)
    );

    rv_ctrl_gen ctrl_gen_i
    (
        .i_grp       (grp),
        .i_alu_op    (alu_op),
        .o_alu_res   (o_alu_res),
        .o_alu_ctrl  (o_alu_ctrl),
        .o_res_src   (o_res_src),
        .o_op1_src   (o_op1_src),
        .o_op2_src   (o_op2_src),
        .o_reg_write (o_reg_write)
    );

endmodule

/* hdl/rv_imm_gen.sv */
`timescale 1ns/1ns

module rv_imm_gen
(
    input  logic [rv_decode_pkg::XLEN-1:0] i_instruction,
    input  rv_decode_pkg::instr_grp_t      i_grp,
    output logic [rv_decode_pkg::XLEN-1:0] o_imm_i,
    output logic [rv_decode_pkg::XLEN-1:0] o_imm_j
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            sign;

    assign sign = i_instruction[31];

    assign imm_i = {{21{sign}}, i_instruction[30:20]};
    assign imm_s = {{21{sign}}, i_instruction[30:25], i_instruction[11:7]};
    assign imm_b = {{20{sign}}, i_instruction[7], i_instruction[30:25],
                    i_instruction[11:8], 1'b0};
    assign imm_u = {i_instruction[31:12], 12'b0};
    assign imm_j = {{12{sign}}, i_instruction[19:12], i_instruction[20],
                    i_instruction[30:21], 1'b0};

    // operand immediate for the alu
    assign o_imm_i = (i_grp.lui || i_grp.auipc) ? imm_u :
                     i_grp.store                ? imm_s : imm_i;

    // jump target offset
    assign o_imm_j = i_grp.jal ? imm_j : imm_b;

endmodule

/* hdl/rv_op_decode.sv */
`timescale 1ns/1ns

module rv_op_decode
#(
    parameter int EXTENSION_ZICSR = 0
)
(
    input  logic [rv_decode_pkg::XLEN-1:0]       i_instruction,
    output rv_decode_pkg::instr_grp_t            o_grp,
    output rv_decode_pkg::alu_op_e               o_alu_op,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [2:0]                           o_funct3,
    output logic [rv_decode_pkg::CSR_ADDR_W-1:0] o_csr_idx,
    output logic [4:0]                           o_csr_imm,
    output logic                                 o_csr_imm_sel,
    output logic                                 o_csr_write,
    output logic                                 o_csr_set,
    output logic                                 o_csr_clear,
    output logic                                 o_csr_read,
    output logic                                 o_csr_ebreak,
    output logic                                 o_inst_mret,
    output logic                                 o_inst_branch,
    output logic                                 o_inst_jal,
    output logic                                 o_inst_jalr,
    output logic                                 o_inst_store,
    output logic                                 o_inst_supported
);

    import rv_decode_pkg::*;

    logic        full;
    logic [4:0]  opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        f7_base;
    logic        f7_alt;
    logic        sys_fn0;
    logic        inst_ecall;
    logic        inst_ebreak;
    logic        inst_mret;
    logic        inst_csr;
    logic        base_ok;

    assign full    = (i_instruction[1:0] == OPC_FULL);
    assign opc     = i_instruction[6:2];
    assign funct3  = i_instruction[14:12];
    assign funct7  = i_instruction[31:25];
    assign funct12 = i_instruction[31:20];
    assign f7_base = (funct7 == FUNCT7_BASE);
    assign f7_alt  = (funct7 == FUNCT7_ALT);

    always_comb
    begin
        o_grp = '0;
        if (full)
        begin
            case (opc)
                OPC_LD:   o_grp.load   = 1'b1;
                OPC_STR:  o_grp.store  = 1'b1;
                OPC_ARI:  o_grp.imm    = 1'b1;
                OPC_ARR:  o_grp.reg_op = 1'b1;
                OPC_B:    o_grp.branch = 1'b1;
                OPC_LUI:  o_grp.lui    = 1'b1;
                OPC_AUI:  o_grp.auipc  = 1'b1;
                OPC_JAL:  o_grp.jal    = 1'b1;
                OPC_JALR: o_grp.jalr   = 1'b1;
                OPC_SYS:  o_grp.sys    = 1'b1;
                default:  o_grp        = '0;
            endcase
        end
    end

    // funct7 only matters for register ops and immediate shifts
    always_comb
    begin
        o_alu_op = ALU_NONE;
        if (o_grp.load || o_grp.store)
            o_alu_op = ADD;
        else if (o_grp.imm || o_grp.reg_op)
        begin
            case (funct3)
                3'b000:
                begin
                    if (o_grp.imm || f7_base)
                        o_alu_op = ADD;
                    else if (f7_alt)
                        o_alu_op = SUB;
                end
                3'b001:  o_alu_op = f7_base ? SLL : ALU_NONE;
                3'b010:  o_alu_op = (o_grp.imm || f7_base) ? SLT : ALU_NONE;
                3'b011:  o_alu_op = (o_grp.imm || f7_base) ? SLTU : ALU_NONE;
                3'b100:  o_alu_op = (o_grp.imm || f7_base) ? XOR : ALU_NONE;
                3'b101:  o_alu_op = f7_base ? SRL : (f7_alt ? SRA : ALU_NONE);
                3'b110:  o_alu_op = (o_grp.imm || f7_base) ? OR : ALU_NONE;
                default: o_alu_op = (o_grp.imm || f7_base) ? AND : ALU_NONE;
            endcase
        end
        else if (o_grp.branch)
        begin
            case (funct3)
                3'b000:  o_alu_op = BEQ;
                3'b001:  o_alu_op = BNE;
                3'b100:  o_alu_op = BLT;
                3'b101:  o_alu_op = BGE;
                3'b110:  o_alu_op = BLTU;
                3'b111:  o_alu_op = BGEU;
                default: o_alu_op = ALU_NONE;
            endcase
        end
    end

    assign o_rd     = i_instruction[11:7];
    assign o_rs1    = o_grp.lui ? '0 : i_instruction[19:15];
    assign o_rs2    = i_instruction[24:20];
    assign o_funct3 = full ? funct3 : 3'b010;

    // system functions share funct3 zero
    assign sys_fn0     = o_grp.sys && (funct3 == 3'b000);
    assign inst_ecall  = sys_fn0 && (funct12 == FUNCT12_ECALL);
    assign inst_ebreak = sys_fn0 && (funct12 == FUNCT12_EBREAK);
    assign inst_mret   = sys_fn0 && (funct12 == FUNCT12_MRET);
    assign inst_csr    = o_grp.sys && (funct3[1:0] != 2'b00);

    assign o_csr_idx     = funct12;
    assign o_csr_imm     = i_instruction[19:15];
    assign o_csr_imm_sel = funct3[2];
    assign o_csr_write   = o_grp.sys && (funct3[1:0] == 2'b01);
    assign o_csr_set     = o_grp.sys && (funct3[1:0] == 2'b10);
    assign o_csr_clear   = o_grp.sys && (funct3[1:0] == 2'b11);
    assign o_csr_read    = o_grp.sys;
    assign o_csr_ebreak  = inst_ebreak;
    assign o_inst_mret   = inst_mret;

    assign o_inst_branch = o_grp.branch;
    assign o_inst_jal    = o_grp.jal;
    assign o_inst_jalr   = o_grp.jalr;
    assign o_inst_store  = o_grp.store;

    // alu, branch and memory ops are valid once an alu op is found
    assign base_ok = ((o_grp.imm || o_grp.reg_op || o_grp.branch) && (o_alu_op != ALU_NONE))
                   || (o_grp.load && (funct3 != 3'b011) && (funct3[2:1] != 2'b11))
                   || (o_grp.store && (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11))
                   || (o_grp.jalr && (funct3 == 3'b000))
                   || o_grp.lui || o_grp.auipc || o_grp.jal
                   || inst_ecall || inst_ebreak;

    assign o_inst_supported = (i_instruction == '0) || base_ok
                            || ((inst_csr || inst_mret) && (EXTENSION_ZICSR != 0));

endmodule

/* hdl/rv_stage_reg.sv */
`timescale 1ns/1ns

module rv_stage_reg
(
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_stall,
    input  logic                           i_flush,
    input  logic [rv_decode_pkg::XLEN-1:0] i_instruction,
    input  logic [rv_decode_pkg::XLEN-1:0] i_pc,
    output logic [rv_decode_pkg::XLEN-1:0] o_instruction,
    output logic [rv_decode_pkg::XLEN-1:0] o_pc,
    output logic [rv_decode_pkg::XLEN-1:0] o_pc_next
);

    import rv_decode_pkg::*;

    // a zero word decodes as a bubble
    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
            o_instruction <= '0;
        else if (!i_stall)
            o_instruction <= i_instruction;
    end

    // pc keeps its value across a flush
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_pc <= '0;
        else if (!i_flush && !i_stall)
            o_pc <= i_pc;
    end

    // no compressed instructions, always a 4 byte step
    assign o_pc_next = o_pc + XLEN'(4);

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_decode -f src.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src.f */
hdl/rv_decode_pkg.sv
hdl/rv_stage_reg.sv
hdl/rv_op_decode.sv
hdl/rv_imm_gen.sv
hdl/rv_ctrl_gen.sv
hdl/rv_decode_top.sv
tb/tb_rv_decode_assert.sv
tb/tb_rv_decode.sv

/* tb/tb_rv_decode.sv */
`timescale 1ns/1ns

module tb_rv_decode;

    import rv_decode_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = 300;
    localparam int RANDOM_COUNT    = 200;

    logic                      i_clk;
    logic                      i_rst;
    logic                      i_stall;
    logic                      i_flush;
    logic [XLEN-1:0]           i_instruction;
    logic [XLEN-1:0]           i_pc;
    logic [CSR_ADDR_W-1:0]     o_csr_idx;
    logic [4:0]                o_csr_imm;
    logic                      o_csr_imm_sel;
    logic                      o_csr_write;
    logic                      o_csr_set;
    logic                      o_csr_clear;
    logic                      o_csr_read;
    logic                      o_csr_ebreak;
    logic [XLEN-1:0]           o_pc;
    logic [XLEN-1:0]           o_pc_next;
    logic [REG_ADDR_W-1:0]     o_rs1;
    logic [REG_ADDR_W-1:0]     o_rs2;
    logic [REG_ADDR_W-1:0]     o_rd;
    logic [XLEN-1:0]           o_imm_i;
    logic [XLEN-1:0]           o_imm_j;
    alu_res_t                  o_alu_res;
    alu_ctrl_t                 o_alu_ctrl;
    logic [2:0]                o_funct3;
    res_src_t                  o_res_src;
    logic                      o_reg_write;
    src_op1_t                  o_op1_src;
    src_op2_t                  o_op2_src;
    logic                      o_inst_mret;
    logic                      o_inst_jalr;
    logic                      o_inst_jal;
    logic                      o_inst_branch;
    logic                      o_inst_store;
    logic                      o_inst_supported;

    // expected alu controls per op, in alu_ctrl_t bit order
    logic [2:0]  alu_f3[10];
    logic [6:0]  alu_f7[10];
    logic [3:0]  alu_res_exp[10];
    logic [11:0] alu_ctrl_exp[10];

    rv_decode_top
    #(
        .EXTENSION_ZICSR (1)
    )
    dut_i
    (
        .*
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STR, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_B, 2'b11};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [4:0] opc);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
    endfunction

    function automatic logic [31:0] enc_sys(input logic [11:0] f12, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {f12, rs1, f3, rd, OPC_SYS, 2'b11};
    endfunction

    // drive one word, return 1 ns after the edge that loaded it
    task automatic load(input logic [31:0] instr, input logic [31:0] pc);
        i_instruction = instr;
        i_pc          = pc;
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_bubble(input string name);
        check_val({name, " reg_write"}, 0, o_reg_write);
        check_val({name, " store"}, 0, o_inst_store);
        check_val({name, " branch/jumps"}, 0, {o_inst_branch, o_inst_jal, o_inst_jalr});
        check_val({name, " mret"}, 0, o_inst_mret);
        check_val({name, " csr strobes"}, 0,
                  {o_csr_write, o_csr_set, o_csr_clear, o_csr_read, o_csr_ebreak});
        check_val({name, " supported"}, 1, o_inst_supported);
        check_val({name, " funct3"}, 3'b010, o_funct3);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("timeout: the decode tests did not finish in time");
    end

    always @(dut_i.assert_i.err_count)
    begin
        if (dut_i.assert_i.err_count != 0)
            fail_run("a concurrent assertion in the bound checker failed");
    end

    initial
    begin
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        logic [20:0] imm21;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [31:0] pc;
        logic [31:0] exp_imm_i;
        logic [31:0] exp_imm_j;
        logic [31:0] exp_pc;
        logic [31:0] exp_ctrl;
        int          kind;

        i_clk         = 1'b0;
        i_rst         = 1'b1;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        // a live add during reset, which reset must still clear
        i_instruction = enc_i(12'h00b, 5'd1, 3'd0, 5'd3, OPC_ARI);
        i_pc          = 32'h80;
        void'($urandom(32'h376c298f));

        alu_f3       = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alu_f7       = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        alu_res_exp  = '{4'b0001, 4'b0001, 4'b0010, 4'b1000, 4'b1000,
                         4'b0100, 4'b0010, 4'b0010, 4'b0100, 4'b0100};
        alu_ctrl_exp = '{12'b000000000010, 12'b000000000100, 12'b000000010000,
                         12'b010000000000, 12'b001000000000, 12'b000000100000,
                         12'b000000001000, 12'b000000001001, 12'b000001000000,
                         12'b000010000000};

        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        check_bubble("reset");
        check_val("reset pc", 0, o_pc);

        // flush over a valid add keeps the pc
        load(enc_i(12'h005, 5'd1, 3'd0, 5'd2, OPC_ARI), 32'h100);
        i_flush = 1'b1;
        load(enc_i(12'h007, 5'd3, 3'd0, 5'd4, OPC_ARI), 32'h200);
        i_flush = 1'b0;
        check_bubble("flush");
        check_val("flush pc", 32'h100, o_pc);

        for (int n = 0; n < RANDOM_COUNT; n++)
        begin
            kind  = $urandom % 5;
            rd    = 5'($urandom);
            rs1   = 5'($urandom);
            imm12 = 12'($urandom);
            imm13 = 13'($urandom) & 13'h1ffe;
            imm20 = 20'($urandom);
            imm21 = 21'($urandom) & 21'h1ffffe;
            case (kind)
                0:
                begin
                    load(enc_i(imm12, rs1, 3'd0, rd, OPC_ARI), 32'h0);
                    check_val("rand I imm", {{20{imm12[11]}}, imm12}, o_imm_i);
                    check_val("rand I rd", 32'(rd), 32'(o_rd));
                    check_val("rand I rs1", 32'(rs1), 32'(o_rs1));
                end
                1:
                begin
                    load(enc_s(imm12, rd, rs1, 3'd2), 32'h0);
                    check_val("rand S imm", {{20{imm12[11]}}, imm12}, o_imm_i);
                    check_val("rand S store", 1, o_inst_store);
                    check_val("rand S rs2", 32'(rd), 32'(o_rs2));
                end
                2:
                begin
                    load(enc_u(imm20, rd, (n % 2 == 0) ? OPC_LUI : OPC_AUI), 32'h0);
                    check_val("rand U imm", {imm20, 12'h000}, o_imm_i);
                    if (n % 2 == 0)
                        check_val("rand lui rs1", 0, 32'(o_rs1));
                end
                3:
                begin
                    load(enc_b(imm13, rd, rs1, 3'd0), 32'h0);
                    check_val("rand B imm", {{19{imm13[12]}}, imm13}, o_imm_j);
                end
                default:
                begin
                    load(enc_j(imm21, rd), 32'h0);
                    check_val("rand J imm", {{11{imm21[20]}}, imm21}, o_imm_j);
                end
            endcase
        end

        // register and immediate alu ops
        for (int k = 0; k < 10; k++)
        begin
            load(enc_r(alu_f7[k], 5'd3, 5'd2, alu_f3[k], 5'd1, OPC_ARR), 32'h0);
            check_val($sformatf("R%0d alu_res", k), 32'(alu_res_exp[k]), 32'(o_alu_res));
            check_val($sformatf("R%0d alu_ctrl", k), 32'(alu_ctrl_exp[k]), 32'(o_alu_ctrl));
            check_val($sformatf("R%0d srcs", k), 32'b01_001_001_1,
                      32'({o_op1_src, o_op2_src, o_res_src, o_reg_write}));
            check_val($sformatf("R%0d rs2", k), 3, 32'(o_rs2));
            check_val($sformatf("R%0d funct3", k), 32'(alu_f3[k]), 32'(o_funct3));
            if (k != 1)
            begin
                load(enc_i({alu_f7[k], 5'd3}, 5'd2, alu_f3[k], 5'd1, OPC_ARI), 32'h0);
                check_val($sformatf("I%0d alu_res", k), 32'(alu_res_exp[k]), 32'(o_alu_res));
                check_val($sformatf("I%0d alu_ctrl", k), 32'(alu_ctrl_exp[k]),
                          32'(o_alu_ctrl));
                check_val($sformatf("I%0d srcs", k), 32'b01_010_001_1,
                          32'({o_op1_src, o_op2_src, o_res_src, o_reg_write}));
            end
        end

        // branches in {branch, inversed, ltu} bit order
        for (int k = 0; k < 6; k++)
        begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            pc = 32'h1000 + 32'(k * 16);
            load(enc_b(13'h010, 5'd5, 5'd6, f3), pc);
            check_val($sformatf("branch f3=%0d flags", f3), {29'd0, 1'b1, f3[0], f3[1]},
                      {29'd0, o_inst_branch, o_alu_ctrl.cmp_inversed, o_alu_ctrl.cmp_ltu});
            check_val("branch pc_next", pc + 32'd4, o_pc_next);
        end
        load(enc_j(21'h000800, 5'd1), 32'h2000);
        check_val("jal flags", 32'b1_0_10_100_010, 32'({o_inst_jal, o_inst_jalr, o_op1_src,
                  o_op2_src, o_res_src}));
        check_val("jal pc_next", 32'h2004, o_pc_next);
        load(enc_i(12'h010, 5'd1, 3'd0, 5'd1, OPC_JALR), 32'h3000);
        check_val("jalr flags", 32'b0_1_01_010_010, 32'({o_inst_jal, o_inst_jalr, o_op1_src,
                  o_op2_src, o_res_src}));
        check_val("jalr pc_next", 32'h3004, o_pc_next);

        // csrrw, csrrs, csrrc and then their immediate forms
        // strobes in {write, set, clear, read, imm_sel} bit order
        for (int k = 0; k < 6; k++)
        begin
            f3 = (k < 3) ? 3'(k + 1) : 3'(k + 2);
            load(enc_sys(12'h340 + 12'(k), 5'(k + 9), f3, 5'd7), 32'h0);
            check_val($sformatf("csr f3=%0d strobes", f3),
                      {27'd0, (k % 3) == 0, (k % 3) == 1, (k % 3) == 2, 1'b1, k >= 3},
                      {27'd0, o_csr_write, o_csr_set, o_csr_clear, o_csr_read, o_csr_imm_sel});
            check_val("csr idx", 32'h340 + 32'(k), 32'(o_csr_idx));
            check_val("csr imm", 32'(k + 9), 32'(o_csr_imm));
            check_val("csr supported", 1, o_inst_supported);
        end
        load(enc_sys(12'h302, 5'd0, 3'd0, 5'd0), 32'h0);
        check_val("mret", 3'b101, {o_inst_mret, o_csr_ebreak, o_inst_supported});
        load(enc_sys(12'h001, 5'd0, 3'd0, 5'd0), 32'h0);
        check_val("ebreak", 3'b011, {o_inst_mret, o_csr_ebreak, o_inst_supported});
        load(enc_sys(12'h000, 5'd0, 3'd0, 5'd0), 32'h0);
        check_val("ecall", 3'b001, {o_inst_mret, o_csr_ebreak, o_inst_supported});
        load({25'd0, 5'b11110, 2'b11}, 32'h0);
        check_val("undefined opcode supported", 0, o_inst_supported);
        load(enc_r(7'h01, 5'd3, 5'd2, 3'd0, 5'd1, OPC_ARR), 32'h0);
        check_val("bad funct7 supported", 0, o_inst_supported);

        // stall hold while the input word keeps changing
        load(enc_i(12'h123, 5'd4, 3'd0, 5'd8, OPC_ARI), 32'h4000);
        // branch-format view of this addi word is 0x128
        exp_imm_i = 32'h0000_0123;
        exp_imm_j = 32'h0000_0128;
        exp_pc    = 32'h4000;
        exp_ctrl  = 32'({5'd8, 5'd4, 12'b000000000010, 4'b0001, 1'b1});
        i_stall   = 1'b1;
        for (int k = 0; k < 4; k++)
        begin
            load(enc_u(20'($urandom), 5'(k), OPC_LUI), 32'h5000 + 32'(k * 4));
            check_val("stall imm_i", exp_imm_i, o_imm_i);
            check_val("stall imm_j", exp_imm_j, o_imm_j);
            check_val("stall pc", exp_pc, o_pc);
            check_val("stall ctrl", exp_ctrl,
                      32'({o_rd, o_rs1, o_alu_ctrl, o_alu_res, o_reg_write}));
        end
        i_stall = 1'b0;
        load('0, 32'h0);

        if (dut_i.assert_i.err_count != 0)
        begin
            $display("concurrent assertion failures were reported");
            $display("Simulation failed");
            $fatal(1);
        end
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* tb/tb_rv_decode_assert.sv */
`timescale 1ns/1ns

module tb_rv_decode_assert
(
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_stall,
    input logic        i_flush,
    input logic [31:0] i_pc,
    input logic [31:0] o_pc,
    input logic [31:0] o_pc_next,
    input logic [31:0] o_imm_i,
    input logic        o_reg_write,
    input logic        o_inst_store,
    input logic [3:0]  o_alu_res,
    input logic [2:0]  o_res_src,
    input logic [2:0]  o_op2_src
);

    int err_count = 0;

    // held stage keeps every output
    stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_stall && !i_flush) |=> ($stable(o_pc) && $stable(o_imm_i) && $stable(o_reg_write)))
        else
        begin
            $error("stall did not hold the stage");
            err_count++;
        end

    flush_bubble: assert property (@(posedge i_clk) i_flush |=> (!o_reg_write && !o_inst_store))
        else
        begin
            $error("flush left write or store strobes set");
            err_count++;
        end

    // a loaded pc and its 4 byte successor
    pc_step: assert property (@(posedge i_clk) disable iff (i_rst)
        (!i_stall && !i_flush) |=> (o_pc == $past(i_pc) && o_pc_next == $past(i_pc) + 32'd4))
        else
        begin
            $error("loaded pc or next pc is wrong");
            err_count++;
        end

    // alu group may be idle for non alu instructions
    src_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot(o_res_src) && $onehot(o_op2_src) && $onehot0(o_alu_res))
        else
        begin
            $error("select vector is not one-hot");
            err_count++;
        end

endmodule

bind rv_decode_top tb_rv_decode_assert assert_i
(
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (i_stall),
    .i_flush      (i_flush),
    .i_pc         (i_pc),
    .o_pc         (o_pc),
    .o_pc_next    (o_pc_next),
    .o_imm_i      (o_imm_i),
    .o_reg_write  (o_reg_write),
    .o_inst_store (o_inst_store),
    .o_alu_res    (o_alu_res),
    .o_res_src    (o_res_src),
    .o_op2_src    (o_op2_src)
);
